/* logic/data_fifo.sv */
/*
  synchronous first-word-fall-through fifo.
  FIFO_DEPTH must be a power of two, at least 2.
  push while full and pop while empty are dropped.
*/
module data_fifo
   import sd_bus_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
) (
   input  logic      CLK,
   input  logic      rst,
   dma_fifo_if.fifo  fifo,
   input  logic      card_pop,
   output data_t     card_rdata
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   data_t            mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;  // occupancy
   logic             do_push;
   logic             do_pop;

   assign fifo.full  = (count_q == CNT_W'(FIFO_DEPTH));
   assign fifo.empty = (count_q == '0);

   // engine pops in the to-RAM direction, card pops in the other
   assign do_push = fifo.push && !fifo.full;
   assign do_pop  = (fifo.pop || card_pop) && !fifo.empty;

   //////////////////////////////
   // storage
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem[wr_ptr_q] <= fifo.wdata;
      end
   end

   // head word, visible without a pop
   assign fifo.rdata = mem[rd_ptr_q];
   assign card_rdata = mem[rd_ptr_q];

   //////////////////////////////
   // pointers and count
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(1);  // wraps at depth
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(1);
         end
         if (do_push && !do_pop) begin
            count_q <= count_q + CNT_W'(1);
         end else if (do_pop && !do_push) begin
            count_q <= count_q - CNT_W'(1);
         end
      end
   end

endmodule

/* logic/dma_ctrl_fsm.sv */
/*
  transfer state machine. start only counts while idle (tfc high).
  read direction keeps at most one RAM read in flight; RAM read latency
  is assumed to be exactly one cycle.
*/
module dma_ctrl_fsm
   import sd_dma_pkg::*;
(
   input  logic       CLK,
   input  logic       rst,
   input  logic       start,
   input  xfer_dir_e  direction,
   input  logic       length_zero,  // no words left to issue
   output logic       tfc,
   output logic       ram_read,
   output logic       ram_write,
   dma_cnt_if.fsm     cnt,
   dma_fifo_if.fsm    fifo,
   input  logic       hold_busy,    // read path holds a word
   input  logic       hold_push     // held word goes into the fifo now
);

   xfer_state_e state_q;
   xfer_state_e state_d;
   logic        rd_inflight_q;  // read issued last cycle, data on the bus now
   logic        hold_free;
   logic        can_read;

   assign tfc = (state_q == IDLE);

   // hold register is empty or drains this cycle
   assign hold_free = !hold_busy || hold_push;
   assign can_read  = !rd_inflight_q && hold_free;

   //////////////////////////////
   // next state and strobes
   //////////////////////////////
   always_comb begin
      state_d   = state_q;
      ram_read  = 1'b0;
      ram_write = 1'b0;
      fifo.pop  = 1'b0;
      cnt.load  = 1'b0;
      cnt.step  = 1'b0;

      case (state_q)
         IDLE: begin
            if (start) begin
               cnt.load = 1'b1;
               state_d  = (direction == DIR_TO_FIFO) ? RAM_FIFO : FIFO_RAM;
            end
         end

         FIFO_RAM: begin
            if (length_zero) begin
               state_d = IDLE;  // zero length, nothing to write
            end else if (fifo.empty) begin
               state_d = WAIT_READ;
            end else begin
               ram_write = 1'b1;  // head word to RAM
               fifo.pop  = 1'b1;
               cnt.step  = 1'b1;
               if (cnt.last) begin
                  state_d = IDLE;
               end
            end
         end

         WAIT_READ: begin
            if (!fifo.empty) begin
               state_d = FIFO_RAM;
            end
         end

         RAM_FIFO: begin
            if (hold_busy && fifo.full) begin
               state_d = WAIT_WRITE;
            end else if (length_zero) begin
               // all reads issued, wait for the last word to land
               if (!rd_inflight_q) begin
                  state_d = IDLE;
               end
            end else if (can_read) begin
               ram_read = 1'b1;
               cnt.step = 1'b1;
            end
         end

         WAIT_WRITE: begin
            if (hold_push) begin
               state_d = length_zero ? IDLE : RAM_FIFO;
            end
         end

         default: begin
            state_d = IDLE;
         end
      endcase
   end

   //////////////////////////////
   // state registers
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst) begin
         state_q       <= IDLE;
         rd_inflight_q <= 1'b0;
      end else begin
         state_q       <= state_d;
         rd_inflight_q <= ram_read;
      end
   end

endmodule

/* logic/dma_ifs.sv */
/*
  internal buses of the transfer engine.
  dma_cnt_if: load is a one-cycle pulse, a step with last high ends the count.
  dma_fifo_if: push while full and pop while empty are not allowed.
*/

// counter control between FSM and address generator
interface dma_cnt_if import sd_bus_pkg::*; ();
   logic  load;     // latch start address and word count
   logic  step;     // one word moved
   addr_t address;  // current word address
   logic  last;     // exactly one word left

   modport fsm     (output load, output step, input last);
   modport counter (input load, input step, output address, output last);
   // read-only view of the running address
   modport path    (input address, input last);
endinterface

// engine side of the data fifo
interface dma_fifo_if import sd_bus_pkg::*; ();
   logic  push;
   data_t wdata;
   logic  pop;
   data_t rdata;  // head word, fall-through
   logic  full;
   logic  empty;

   modport fifo (input push, input wdata, input pop,
                 output rdata, output full, output empty);
   modport fsm  (output pop, input full, input empty);
   modport path (output push, output wdata, input full);
endinterface

/* logic/dma_read_path.sv */
/*
  one-entry hold register between RAM read data and the fifo.
  expects data_from_ram valid the cycle after ram_read.
  in the to-RAM direction the card side owns the fifo write port.
*/
module dma_read_path
   import sd_bus_pkg::*;
(
   input  logic      CLK,
   input  logic      rst,
   input  logic      ram_read,
   input  data_t     data_from_ram,
   output logic      hold_busy,
   output logic      hold_push,
   dma_fifo_if.path  fifo,
   input  logic      card_push,
   input  data_t     card_wdata,
   input  logic      dir_to_fifo
);

   logic  rd_pending_q;  // RAM data valid this cycle
   logic  hold_valid_q;
   data_t hold_data_q;

   assign hold_busy = hold_valid_q;
   assign hold_push = hold_valid_q && !fifo.full;

   //////////////////////////////
   // hold register
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst) begin
         rd_pending_q <= 1'b0;
         hold_valid_q <= 1'b0;
      end else begin
         rd_pending_q <= ram_read;
         if (rd_pending_q) begin
            hold_valid_q <= 1'b1;
         end else if (hold_push) begin
            hold_valid_q <= 1'b0;  // word now in the fifo
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (rd_pending_q) begin
         hold_data_q <= data_from_ram;
      end
   end

   // single writer: hold register or card port
   assign fifo.push  = dir_to_fifo ? hold_push : (card_push && !fifo.full);
   assign fifo.wdata = dir_to_fifo ? hold_data_q : card_wdata;

endmodule

/* logic/dma_word_counter.sv */
/*
  address generator and remaining-word counter.
  the low two bits of length are dropped; the address wraps at 2**64.
*/
module dma_word_counter
   import sd_bus_pkg::*;
(
   input  logic       CLK,
   input  logic       rst,
   input  addr_t      address_init,
   input  len_t       length,
   output logic       length_zero,
   dma_cnt_if.counter cnt
);

   localparam int WORD_CNT_W = LEN_W - 2;  // bytes to words

   addr_t                 addr_q;
   logic [WORD_CNT_W-1:0] words_q;  // words still to move

   //////////////////////////////
   // counters
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst) begin
         addr_q  <= '0;
         words_q <= '0;
      end else if (cnt.load) begin
         addr_q  <= address_init;
         words_q <= length[LEN_W-1:2];
      end else if (cnt.step) begin
         addr_q  <= addr_q + addr_t'(WORD_BYTES);
         words_q <= words_q - WORD_CNT_W'(1);
      end
   end

   assign cnt.address = addr_q;
   assign cnt.last    = (words_q == WORD_CNT_W'(1));

   // zero right after loading an empty transfer, or once the count ran out
   assign length_zero = (words_q == '0);

endmodule

/* logic/sd_bus_pkg.sv */
/*
  system bus and length widths, fixed by the SD host register map.
  length counts bytes; only whole 32-bit words are moved.
*/
package sd_bus_pkg;

   //////////////////////////////
   // bus widths
   //////////////////////////////
   localparam int ADDR_W = 64;  // system address
   localparam int DATA_W = 32;  // one RAM / FIFO word
   localparam int LEN_W  = 16;  // byte length register

   // address step per word
   localparam int unsigned WORD_BYTES = DATA_W / 8;

   //////////////////////////////
   // vector types
   //////////////////////////////
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [LEN_W-1:0]  len_t;

endpackage

/* logic/sd_dma_pkg.sv */
/*
  transfer engine encodings.
  states are one-hot; direction matches the single-bit register field.
*/
package sd_dma_pkg;

   //////////////////////////////
   // transfer states
   //////////////////////////////
   typedef enum logic [4:0] {
      IDLE       = 5'b00001,  // tfc high, waiting for start
      FIFO_RAM   = 5'b00010,  // card data out to system RAM
      RAM_FIFO   = 5'b00100,  // system RAM in to card FIFO
      WAIT_READ  = 5'b01000,  // fifo empty while writing RAM
      WAIT_WRITE = 5'b10000   // hold register stuck on a full fifo
   } xfer_state_e;

   //////////////////////////////
   // transfer direction
   //////////////////////////////
   // value follows the direction bit of the host register
   typedef enum logic {
      DIR_TO_RAM  = 1'b0,
      DIR_TO_FIFO = 1'b1
   } xfer_dir_e;

endpackage

/* logic/sd_dma_top.sv */
/*
  SD host data-transfer engine top level.
  RAM is external with one-cycle read latency; the card side is the fifo.
  direction must stay stable while tfc is low.
*/
module sd_dma_top
   import sd_bus_pkg::*;
   import sd_dma_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
) (
   input  logic      CLK,
   input  logic      rst,
   // control
   input  logic      start,
   input  xfer_dir_e direction,
   input  addr_t     address_init,
   input  len_t      length,
   output logic      tfc,
   // system RAM
   output logic      ram_read,
   output logic      ram_write,
   output addr_t     ram_address,
   output data_t     data_to_ram,
   input  data_t     data_from_ram,
   // card side of the fifo
   input  logic      card_push,
   input  data_t     card_wdata,
   input  logic      card_pop,
   output data_t     card_rdata,
   output logic      fifo_full,
   output logic      fifo_empty
);

   logic length_zero;
   logic hold_busy;
   logic hold_push;
   logic dir_to_fifo;

   dma_cnt_if  cnt_bus ();
   dma_fifo_if fifo_bus ();

   assign dir_to_fifo = (direction == DIR_TO_FIFO);

   dma_ctrl_fsm u_fsm (
      .CLK         (CLK),
      .rst         (rst),
      .start       (start),
      .direction   (direction),
      .length_zero (length_zero),
      .tfc         (tfc),
      .ram_read    (ram_read),
      .ram_write   (ram_write),
      .cnt         (cnt_bus.fsm),
      .fifo        (fifo_bus.fsm),
      .hold_busy   (hold_busy),
      .hold_push   (hold_push)
   );

   dma_word_counter u_counter (
      .CLK          (CLK),
      .rst          (rst),
      .address_init (address_init),
      .length       (length),
      .length_zero  (length_zero),
      .cnt          (cnt_bus.counter)
   );

   dma_read_path u_read_path (
      .CLK           (CLK),
      .rst           (rst),
      .ram_read      (ram_read),
      .data_from_ram (data_from_ram),
      .hold_busy     (hold_busy),
      .hold_push     (hold_push),
      .fifo          (fifo_bus.path),
      .card_push     (card_push),
      .card_wdata    (card_wdata),
      .dir_to_fifo   (dir_to_fifo)
   );

   data_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .CLK        (CLK),
      .rst        (rst),
      .fifo       (fifo_bus.fifo),
      .card_pop   (card_pop),
      .card_rdata (card_rdata)
   );

   assign ram_address = cnt_bus.address;
   assign data_to_ram = fifo_bus.rdata;  // fifo head goes out with ram_write
   assign fifo_full   = fifo_bus.full;
   assign fifo_empty  = fifo_bus.empty;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the sd_dma testbench with Verilator.
# Run from the project root.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert \
   -f sd_dma.f \
   --top-module sd_dma_tb \
   -Mdir obj_dir \
   -o sim_sd_dma
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out="$(./obj_dir/sim_sd_dma 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^Regression passed$"; then
   exit 0
fi
exit 1

/* sd_dma.f */
logic/sd_bus_pkg.sv
logic/sd_dma_pkg.sv
logic/dma_ifs.sv
logic/dma_ctrl_fsm.sv
logic/dma_word_counter.sv
logic/dma_read_path.sv
logic/data_fifo.sv
logic/sd_dma_top.sv
tests/sd_dma_chk.sv
tests/sd_dma_tb.sv

/* tests/sd_dma_chk.sv */
/*
  bus and fifo rules of the transfer engine, bound into sd_dma_top.
  checked only outside reset.
*/
module sd_dma_chk (
   input logic CLK,
   input logic rst,
   input logic tfc,
   input logic ram_read,
   input logic ram_write,
   input logic fifo_push,
   input logic fifo_pop,
   input logic fifo_full,
   input logic fifo_empty
);
   timeunit 1ns;
   timeprecision 1ps;

   // one RAM access per cycle
   a_one_access: assert property (@(posedge CLK) disable iff (rst)
      !(ram_read && ram_write))
      else $error("ram_read and ram_write high together");

   a_idle_quiet: assert property (@(posedge CLK) disable iff (rst)
      tfc |-> (!ram_read && !ram_write))
      else $error("RAM access while tfc high");

   a_no_overflow: assert property (@(posedge CLK) disable iff (rst)
      fifo_push |-> !fifo_full)
      else $error("fifo push while full");

   a_no_underflow: assert property (@(posedge CLK) disable iff (rst)
      fifo_pop |-> !fifo_empty)
      else $error("fifo pop while empty");

endmodule

// push and pop requests from both the engine and the card port
bind sd_dma_top sd_dma_chk u_chk (
   .CLK        (CLK),
   .rst        (rst),
   .tfc        (tfc),
   .ram_read   (ram_read),
   .ram_write  (ram_write),
   .fifo_push  (fifo_bus.push || card_push),
   .fifo_pop   (fifo_bus.pop || card_pop),
   .fifo_full  (fifo_bus.full),
   .fifo_empty (fifo_bus.empty)
);

/* tests/sd_dma_tb.sv */
/*
  directed testbench for sd_dma_top, FIFO_DEPTH 8.
  RAM model answers reads one cycle later; inputs change on the falling edge.
*/
module sd_dma_tb
   import sd_bus_pkg::*;
   import sd_dma_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   logic      CLK;
   logic      rst;
   logic      start;
   xfer_dir_e direction;
   addr_t     address_init;
   len_t      length;
   logic      tfc;
   logic      ram_read;
   logic      ram_write;
   addr_t     ram_address;
   data_t     data_to_ram;
   data_t     data_from_ram;
   logic      card_push;
   data_t     card_wdata;
   logic      card_pop;
   data_t     card_rdata;
   logic      fifo_full;
   logic      fifo_empty;

   data_t ram [addr_t];  // sparse RAM contents
   addr_t wr_addr_q[$];
   data_t wr_data_q[$];
   addr_t rd_addr_q[$];
   data_t exp_q[$];

   sd_dma_top #(.FIFO_DEPTH(8)) u_dut (.*);

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   //////////////////////////////
   // RAM model
   //////////////////////////////
   function automatic data_t ram_word(addr_t a);
      if (ram.exists(a)) return ram[a];
      return data_t'(a ^ (a >> 32)) ^ 32'hc3a5_0f69;  // fill follows the address
   endfunction

   always @(posedge CLK) begin
      if (ram_write) begin
         wr_addr_q.push_back(ram_address);
         wr_data_q.push_back(data_to_ram);
         ram[ram_address] = data_to_ram;
      end
      if (ram_read) begin
         rd_addr_q.push_back(ram_address);
         data_from_ram <= ram_word(ram_address);  // one cycle latency
      end
   end

   //////////////////////////////
   // error reporting and compares
   //////////////////////////////
   task automatic fail(string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(string name, data_t got, data_t exp);
      if (got !== exp) fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic check_addr(string name, addr_t got, addr_t exp);
      if (got !== exp) fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic check_flag(string name, bit got, bit exp);
      if (got !== exp) fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   //////////////////////////////
   // drivers
   //////////////////////////////
   task automatic start_xfer(xfer_dir_e dir, addr_t base, len_t len);
      @(negedge CLK);
      start        = 1'b1;
      direction    = dir;
      address_init = base;
      length       = len;
      @(negedge CLK);
      start = 1'b0;
      check_flag("tfc", tfc, 1'b0);  // busy the cycle after start
   endtask

   task automatic wait_tfc(int limit);
      int n;
      for (n = 0; n < limit && !tfc; n++) @(negedge CLK);
      if (!tfc) fail("timeout: transfer never completed (tfc stayed low)");
   endtask

   task automatic push_card(data_t w);
      int n;
      @(negedge CLK);
      for (n = 0; n < 200 && fifo_full; n++) @(negedge CLK);
      if (fifo_full) fail("timeout: fifo stayed full, card push blocked");
      card_push  = 1'b1;
      card_wdata = w;
      exp_q.push_back(w);
      @(negedge CLK);
      card_push = 1'b0;
   endtask

   task automatic pop_check(data_t exp);
      int n;
      for (n = 0; n < 200 && fifo_empty; n++) @(negedge CLK);
      if (fifo_empty) fail("timeout: fifo stayed empty, no word for the card");
      check_data("card_rdata", card_rdata, exp);
      card_pop = 1'b1;
      @(negedge CLK);
      card_pop = 1'b0;
   endtask

   task automatic clear_logs();
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
      exp_q.delete();
   endtask

   // written words must be exp_q in address order, nothing more
   task automatic check_writes(addr_t base);
      check_data("write count", data_t'(wr_addr_q.size()), data_t'(exp_q.size()));
      foreach (exp_q[k]) begin
         check_addr("ram_address", wr_addr_q[k], base + addr_t'(4 * k));
         check_data("data_to_ram", wr_data_q[k], exp_q[k]);
      end
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////
   task automatic test_reset();
      check_flag("tfc", tfc, 1'b1);
      check_flag("ram_read", ram_read, 1'b0);
      check_flag("ram_write", ram_write, 1'b0);
      check_flag("fifo_empty", fifo_empty, 1'b1);
   endtask

   task automatic test_to_ram(addr_t base, int words, bit prefill);
      clear_logs();
      direction = DIR_TO_RAM;
      if (prefill) begin
         for (int k = 0; k < words; k++) push_card($urandom);
         start_xfer(DIR_TO_RAM, base, len_t'(4 * words));
      end else begin
         start_xfer(DIR_TO_RAM, base, len_t'(4 * words));
         for (int k = 0; k < words; k++) begin
            repeat ($urandom % 4) @(negedge CLK);  // gaps empty the fifo
            push_card($urandom);
         end
      end
      wait_tfc(400);
      repeat (3) @(negedge CLK);
      check_writes(base);
      check_flag("fifo_empty", fifo_empty, 1'b1);
   endtask

   task automatic test_to_fifo(addr_t base, int words, int lead);
      int n;
      clear_logs();
      for (int k = 0; k < words; k++) begin
         ram[base + addr_t'(4 * k)] = $urandom;
         exp_q.push_back(ram[base + addr_t'(4 * k)]);
      end
      start_xfer(DIR_TO_FIFO, base, len_t'(4 * words));
      if (lead > 0) begin
         // card idle, fifo fills and the read path stalls
         for (n = 0; n < lead && !fifo_full; n++) @(negedge CLK);
         check_flag("fifo_full", fifo_full, 1'b1);
         repeat (4) @(negedge CLK);
         // eight words in the fifo, one more in the hold register
         check_data("reads while stalled", data_t'(rd_addr_q.size()), 32'd9);
         check_flag("fifo_full", fifo_full, 1'b1);
      end
      foreach (exp_q[k]) begin
         pop_check(exp_q[k]);
         repeat ($urandom % 6) @(negedge CLK);
      end
      wait_tfc(400);
      check_data("read count", data_t'(rd_addr_q.size()), data_t'(words));
      foreach (rd_addr_q[k]) check_addr("read address", rd_addr_q[k], base + addr_t'(4 * k));
      check_data("write count", data_t'(wr_addr_q.size()), 32'h0);
      check_flag("fifo_empty", fifo_empty, 1'b1);
   endtask

   task automatic test_corner();
      // zero length, one busy cycle and no RAM access
      clear_logs();
      start_xfer(DIR_TO_RAM, 64'h0000_0000_0000_4000, 16'h0003);
      wait_tfc(3);
      check_data("access count", data_t'(wr_addr_q.size() + rd_addr_q.size()), 32'h0);
      // second start while busy must not reload
      clear_logs();
      start_xfer(DIR_TO_RAM, 64'h0000_0001_0000_0100, 16'd12);
      @(negedge CLK);
      start        = 1'b1;
      address_init = 64'h0000_0000_0000_9000;
      length       = 16'd40;
      @(negedge CLK);
      start = 1'b0;
      for (int k = 0; k < 3; k++) push_card($urandom);
      wait_tfc(100);
      repeat (4) @(negedge CLK);
      check_writes(64'h0000_0001_0000_0100);
      // back to back, opposite directions
      test_to_ram(64'h0000_0000_0000_a000, 4, 1'b1);
      test_to_fifo(64'h0000_0000_0000_a000, 4, 0);
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      void'($urandom(32'h5160c579));
      rst           = 1'b1;
      start         = 1'b0;
      direction     = DIR_TO_RAM;
      address_init  = '0;
      length        = '0;
      data_from_ram = '0;
      card_push     = 1'b0;
      card_wdata    = '0;
      card_pop      = 1'b0;
      repeat (10) @(negedge CLK);
      rst = 1'b0;
      @(negedge CLK);

      test_reset();
      test_to_ram(64'h0000_0000_1000_0000, 6, 1'b1);
      test_to_ram(64'hffff_ff00_0000_0040, 20, 1'b0);
      test_to_fifo(64'h0000_0002_0000_0800, 20, 40);
      test_corner();

      $display("Regression passed");
      $finish;
   end

endmodule
